// ==== compile.f ====
+incdir+logic
logic/jpeg_pkg.sv
logic/dp_ram.sv
logic/csc_rgb2ycbcr.sv
logic/subsample.sv
logic/chroma_cfg.sv
logic/chroma_frontend_top.sv
tb/tb_chroma_frontend.sv

// ==== logic/chroma_cfg.sv ====
/*
 * Colour front end configuration registers
 * Writes land in pending copies, which move to the active outputs
 * at the next frame start so one frame never mixes settings.
 */
`timescale 1ns/10ps

module chroma_cfg
    import jpeg_pkg::*;
(
    input  logic            clk,
    input  logic            resetn,
    input  logic            we_i,
    input  cfg_addr_t       addr_i,
    input  logic            wdata_i,
    input  logic            frame_valid_i,
    output logic            csc_en_o,
    output subsample_mode_t mode_o
);

logic            pend_csc_en;
subsample_mode_t pend_mode;
logic            frame_valid_q;
logic            frame_start;

assign frame_start = frame_valid_i & ~frame_valid_q;

always_ff @(posedge clk) begin
    if (!resetn) begin
        pend_csc_en   <= 1'b1;
        pend_mode     <= MODE_420;
        frame_valid_q <= 1'b0;
        csc_en_o      <= 1'b1;
        mode_o        <= MODE_420;
    end else begin
        frame_valid_q <= frame_valid_i;
        if (we_i) begin
            case (addr_i)
                CFG_CSC_EN: pend_csc_en <= wdata_i;
                CFG_MODE:   pend_mode   <= subsample_mode_t'(wdata_i);
            endcase
        end
        if (frame_start) begin
            csc_en_o <= pend_csc_en;  // Applied for the whole frame
            mode_o   <= pend_mode;
        end
    end
end

endmodule

// ==== logic/chroma_frontend_top.sv ====
/*
 * Colour front end top level
 * Configuration registers, RGB to YCbCr converter and chroma
 * subsampler in a single pipeline with a shared hold
 */
`timescale 1ns/10ps
`include "jpeg_defines.svh"

module chroma_frontend_top
    import jpeg_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   resetn,
    input  pixel_t                                 pixel_i,
    input  logic                                   pixel_valid_i,
    input  raster_t                                raster_i,
    input  logic                                   hold_i,
    input  logic                                   cfg_we_i,
    input  cfg_addr_t                              cfg_addr_i,
    input  logic                                   cfg_wdata_i,
    output pixel_t                                 pixel_o,
    output logic [2:0]                             comp_valid_o,
    output raster_t                                raster_o,
    output logic                                   eof_o,
    output logic                                   eol_o,
    output logic [$clog2(`JPEG_SENSOR_X_SIZE)-1:0] pixel_count_o,
    output logic [$clog2(`JPEG_SENSOR_Y_SIZE)-1:0] line_count_o,
    output logic                                   hold_o
);

logic            csc_en;
subsample_mode_t mode;
pixel_t          csc_pixel;
logic            csc_valid;
raster_t         csc_raster;

assign hold_o = hold_i;  // Back-pressure to the source

chroma_cfg u_cfg (
    .clk           (clk),
    .resetn        (resetn),
    .we_i          (cfg_we_i),
    .addr_i        (cfg_addr_i),
    .wdata_i       (cfg_wdata_i),
    .frame_valid_i (raster_i.frame_valid),
    .csc_en_o      (csc_en),
    .mode_o        (mode)
);

csc_rgb2ycbcr u_csc (
    .clk      (clk),
    .resetn   (resetn),
    .csc_en_i (csc_en),
    .hold_i   (hold_i),
    .pixel_i  (pixel_i),
    .valid_i  (pixel_valid_i),
    .raster_i (raster_i),
    .pixel_o  (csc_pixel),
    .valid_o  (csc_valid),
    .raster_o (csc_raster)
);

subsample u_sub (
    .clk           (clk),
    .resetn        (resetn),
    .mode_i        (mode),
    .pixel_i       (csc_pixel),
    .valid_i       (csc_valid),
    .raster_i      (csc_raster),
    .hold_i        (hold_i),
    .pixel_o       (pixel_o),
    .comp_valid_o  (comp_valid_o),
    .raster_o      (raster_o),
    .eof_o         (eof_o),
    .eol_o         (eol_o),
    .pixel_count_o (pixel_count_o),
    .line_count_o  (line_count_o)
);

endmodule

// ==== logic/csc_rgb2ycbcr.sv ====
/*
 * RGB to YCbCr colour-space converter
 * Three pipeline stages: coefficient products, rounded sums, then
 * shift, offset and clamp. The bypass passes RGB through with the
 * same latency. Every stage freezes while hold is high.
 */
`timescale 1ns/10ps
`include "jpeg_defines.svh"

module csc_rgb2ycbcr
    import jpeg_pkg::*;
(
    input  logic    clk,
    input  logic    resetn,
    input  logic    csc_en_i,
    input  logic    hold_i,
    input  pixel_t  pixel_i,
    input  logic    valid_i,
    input  raster_t raster_i,
    output pixel_t  pixel_o,
    output logic    valid_o,
    output raster_t raster_o
);

localparam int DW   = `JPEG_DW;
localparam int PW   = 2*DW + 2;     // Signed product
localparam int SW   = PW + 2;       // Three products plus rounding
localparam int MAXV = 2**DW - 1;
// Rows are Y, Cb, Cr; columns weight R, G, B (scaled by 256)
localparam int COEF [9] = '{77, 150, 29, -43, -85, 128, 128, -107, -21};

logic                 adv;
logic signed [DW:0]   comp_s [3];
logic signed [PW-1:0] prod_s1 [9];
logic signed [SW-1:0] sum_s2 [3];
logic signed [SW-1:0] shifted [3];
logic [DW-1:0]        conv [3];
pixel_t               pix_s1, pix_s2;
logic                 valid_s1, valid_s2;
raster_t              raster_s1, raster_s2;
logic                 fs_s2, en_frame, en_sel;

function automatic logic [DW-1:0] clamp(input logic signed [SW-1:0] v);
    if (v < 0)
        return '0;
    else if (v > MAXV)
        return '1;
    else
        return v[DW-1:0];
endfunction

assign adv = ~hold_i;

always_comb begin
    comp_s[0] = $signed({1'b0, pixel_i.c0});  // R
    comp_s[1] = $signed({1'b0, pixel_i.c1});  // G
    comp_s[2] = $signed({1'b0, pixel_i.c2});  // B
end

always_comb begin
    for (int k = 0; k < 3; k++) begin
        shifted[k] = (sum_s2[k] >>> 8) + ((k == 0) ? 0 : 128);  // Chroma offset
        conv[k]    = clamp(shifted[k]);
    end
end

// The enable is taken per frame as its first cycle enters stage 3
assign fs_s2  = raster_s2.frame_valid & ~raster_o.frame_valid;
assign en_sel = fs_s2 ? csc_en_i : en_frame;

always_ff @(posedge clk) begin
    if (adv) begin
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 3; j++) begin
                prod_s1[3*k+j] <= PW'(comp_s[j] * COEF[3*k+j]);
            end
            sum_s2[k] <= prod_s1[3*k] + prod_s1[3*k+1] + prod_s1[3*k+2] + 128;
        end
        pix_s1 <= pixel_i;
        pix_s2 <= pix_s1;
        if (en_sel) begin
            pixel_o.c0 <= conv[0];
            pixel_o.c1 <= conv[1];
            pixel_o.c2 <= conv[2];
        end else begin
            pixel_o <= pix_s2;  // Bypass
        end
    end
end

always_ff @(posedge clk) begin
    if (!resetn) begin
        valid_s1  <= 1'b0;
        valid_s2  <= 1'b0;
        valid_o   <= 1'b0;
        raster_s1 <= '0;
        raster_s2 <= '0;
        raster_o  <= '0;
        en_frame  <= 1'b1;
    end else if (adv) begin
        valid_s1  <= valid_i & raster_i.line_valid;  // Accepted pixel
        valid_s2  <= valid_s1;
        valid_o   <= valid_s2;
        raster_s1 <= raster_i;
        raster_s2 <= raster_s1;
        raster_o  <= raster_s2;
        if (fs_s2)
            en_frame <= csc_en_i;
    end
end

a_hold_freezes: assert property (@(posedge clk) disable iff (!resetn)
    ($past(resetn) && $past(hold_i)) |-> $stable({pixel_o, valid_o, raster_o}));

endmodule

// ==== logic/dp_ram.sv ====
/*
 * Simple dual-port RAM
 * One write port and one registered read port on a single clock.
 * The stored word is a type parameter.
 */
`timescale 1ns/10ps

module dp_ram #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 8
) (
    input  logic                     clk,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] wa_i,
    input  T                         wd_i,
    input  logic                     re_i,
    input  logic [$clog2(DEPTH)-1:0] ra_i,
    output T                         rd_o
);

T mem [DEPTH];

always_ff @(posedge clk) begin
    if (we_i) begin
        mem[wa_i] <= wd_i;
    end
end

always_ff @(posedge clk) begin
    if (re_i) begin
        rd_o <= mem[ra_i];  // Held until the next read
    end
end

// Line buffer is written on even lines and read on odd lines only
a_no_rw_collision: assert property (@(posedge clk) we_i |-> !re_i);

endmodule

// ==== logic/jpeg_defines.svh ====
/*
 * JPEG colour front end, shared build-time constants
 * Frame geometry and the width of one colour component
 */
`ifndef JPEG_DEFINES_SVH
`define JPEG_DEFINES_SVH

// Pixels per line, must be even
`define JPEG_SENSOR_X_SIZE 16

// Lines per frame, must be even
`define JPEG_SENSOR_Y_SIZE 8

// Bits per colour component
`define JPEG_DW 8

`endif

// ==== logic/jpeg_pkg.sv ====
/*
 * JPEG colour front end types
 * Pixel, raster timing, chroma pair sums, register addresses and
 * the chroma subsampling mode
 */
`include "jpeg_defines.svh"

package jpeg_pkg;

    // RGB at the input, YCbCr after conversion
    typedef struct packed {
        logic [`JPEG_DW-1:0] c2;  // B or Cr
        logic [`JPEG_DW-1:0] c1;  // G or Cb
        logic [`JPEG_DW-1:0] c0;  // R or Y
    } pixel_t;

    typedef struct packed {
        logic frame_valid;
        logic line_valid;
    } raster_t;

    // Horizontal pair sums kept in the line buffer
    typedef struct packed {
        logic [`JPEG_DW:0] cb_sum;
        logic [`JPEG_DW:0] cr_sum;
    } chroma_pair_t;

    typedef enum logic {MODE_444 = 1'b0, MODE_420 = 1'b1} subsample_mode_t;

    typedef enum logic {CFG_CSC_EN = 1'b0, CFG_MODE = 1'b1} cfg_addr_t;

endpackage

// ==== logic/subsample.sv ====
/*
 * Chroma subsampler, 4:4:4 or 4:2:0
 * Tracks pixel and line position from the raster levels. In 4:2:0
 * the Cb/Cr pair sums of even lines go to a line buffer and are
 * averaged with the matching pair of the following odd line.
 * Luma always passes at full rate.
 */
`timescale 1ns/10ps
`include "jpeg_defines.svh"

module subsample
    import jpeg_pkg::*;
(
    input  logic                                   clk,
    input  logic                                   resetn,
    input  subsample_mode_t                        mode_i,
    input  pixel_t                                 pixel_i,
    input  logic                                   valid_i,
    input  raster_t                                raster_i,
    input  logic                                   hold_i,
    output pixel_t                                 pixel_o,
    output logic [2:0]                             comp_valid_o,
    output raster_t                                raster_o,
    output logic                                   eof_o,
    output logic                                   eol_o,
    output logic [$clog2(`JPEG_SENSOR_X_SIZE)-1:0] pixel_count_o,
    output logic [$clog2(`JPEG_SENSOR_Y_SIZE)-1:0] line_count_o
);

localparam int DW  = `JPEG_DW;
localparam int PCW = $clog2(`JPEG_SENSOR_X_SIZE);
localparam int LCW = $clog2(`JPEG_SENSOR_Y_SIZE);

logic            adv, pix_in, accept;
logic            eof, eol, fs;
logic [PCW-1:0]  pixel_count;
logic [LCW-1:0]  line_count;
subsample_mode_t mode_q, mode_cur;
logic            is_420, chroma_v;
logic            lb_we, lb_re;
chroma_pair_t    lb_wd, lb_rd;
logic [DW+1:0]   quad_cb, quad_cr;

assign adv    = ~hold_i;
assign pix_in = valid_i & raster_i.line_valid;
assign accept = pix_in & adv;

// raster_o doubles as the delayed input level for edge detection
assign eof = raster_o.frame_valid & ~raster_i.frame_valid;
assign eol = raster_o.line_valid & ~raster_i.line_valid;
assign fs  = raster_i.frame_valid & ~raster_o.frame_valid;

// Mode is fixed for a frame at its first cycle here
assign mode_cur = fs ? mode_i : mode_q;
assign is_420   = (mode_cur == MODE_420);
assign chroma_v = is_420 ? (pix_in & pixel_count[0] & line_count[0]) : pix_in;

assign lb_we = accept & is_420 & ~line_count[0] & pixel_count[0];
assign lb_re = accept & is_420 & line_count[0] & ~pixel_count[0];

// Even pixel chroma is held in pixel_o while its odd partner arrives
always_comb begin
    lb_wd.cb_sum = pixel_o.c1 + pixel_i.c1;
    lb_wd.cr_sum = pixel_o.c2 + pixel_i.c2;
    quad_cb      = lb_rd.cb_sum + pixel_o.c1 + pixel_i.c1 + 2'd2;  // Round half up
    quad_cr      = lb_rd.cr_sum + pixel_o.c2 + pixel_i.c2 + 2'd2;
end

dp_ram #(
    .T     (chroma_pair_t),
    .DEPTH (`JPEG_SENSOR_X_SIZE/2)
) line_buf (
    .clk  (clk),
    .we_i (lb_we),
    .wa_i (pixel_count[PCW-1:1]),
    .wd_i (lb_wd),
    .re_i (lb_re),
    .ra_i (pixel_count[PCW-1:1]),
    .rd_o (lb_rd)
);

always_ff @(posedge clk) begin
    if (!resetn) begin
        pixel_count <= '0;
        line_count  <= '0;
    end else if (adv) begin
        if (eof) begin
            pixel_count <= '0;
            line_count  <= '0;
        end else if (eol) begin
            pixel_count <= '0;
            line_count  <= line_count + 1'b1;
        end else if (pix_in) begin
            pixel_count <= pixel_count + 1'b1;
        end
    end
end

always_ff @(posedge clk) begin
    if (accept) begin
        pixel_o.c0    <= pixel_i.c0;
        pixel_count_o <= pixel_count;
        line_count_o  <= line_count;
        if (!is_420 || !pixel_count[0]) begin
            pixel_o.c1 <= pixel_i.c1;
            pixel_o.c2 <= pixel_i.c2;
        end else if (line_count[0]) begin
            pixel_o.c1 <= quad_cb[DW+1:2];  // 2x2 average
            pixel_o.c2 <= quad_cr[DW+1:2];
        end
    end
end

always_ff @(posedge clk) begin
    if (!resetn) begin
        mode_q       <= MODE_420;
        comp_valid_o <= '0;
        raster_o     <= '0;
        eof_o        <= 1'b0;
        eol_o        <= 1'b0;
    end else if (adv) begin
        if (fs)
            mode_q <= mode_i;
        comp_valid_o <= {chroma_v, chroma_v, pix_in};
        raster_o     <= raster_i;
        eof_o        <= eof;
        eol_o        <= eol;
    end
end

a_chroma_has_luma: assert property (@(posedge clk) disable iff (!resetn)
    |comp_valid_o[2:1] |-> comp_valid_o[0]);

a_420_odd_lines: assert property (@(posedge clk) disable iff (!resetn)
    ((mode_q == MODE_420) && |comp_valid_o[2:1]) |-> line_count_o[0]);

endmodule

// ==== tb/tb_chroma_frontend.sv ====
/*
 * Testbench for the colour front end
 * Sends random RGB frames through every converter and subsampling
 * setting, with and without hold and pixel gaps. The Y, Cb and Cr
 * streams, frame markers and counters are checked against a model.
 */
`timescale 1ns/10ps
`include "jpeg_defines.svh"

module tb_chroma_frontend
    import jpeg_pkg::*;
();

localparam int XS              = `JPEG_SENSOR_X_SIZE;
localparam int YS              = `JPEG_SENSOR_Y_SIZE;
localparam int DW              = `JPEG_DW;
localparam int CLK_PERIOD      = 40;
localparam int NUM_FRAMES      = 7;
localparam int WATCHDOG_CYCLES = NUM_FRAMES * (XS + 8) * YS * 4;

logic                  clk;
logic                  resetn;
pixel_t                pixel_i;
logic                  pixel_valid_i;
raster_t               raster_i;
logic                  hold_i;
logic                  cfg_we_i;
cfg_addr_t             cfg_addr_i;
logic                  cfg_wdata_i;
pixel_t                pixel_o;
logic [2:0]            comp_valid_o;
raster_t               raster_o;
logic                  eof_o;
logic                  eol_o;
logic [$clog2(XS)-1:0] pixel_count_o;
logic [$clog2(YS)-1:0] line_count_o;
logic                  hold_o;

logic [15:0]   lfsr;
bit            stress_on;
bit            pend_csc;
bit            pend_420;
bit            fresh;
pixel_t        frame_pix [YS][XS];
logic [DW-1:0] y_q[$];
logic [DW-1:0] cb_q[$];
logic [DW-1:0] cr_q[$];
bit            frame_420_q[$];
int            exp_px;
int            exp_ln;
int            eol_in_frame;
int            eof_count;
int            luma_seen;
int            chroma_seen;
int            err_value;
int            err_other;

chroma_frontend_top UUT (.*);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
end

// Fibonacci LFSR, taps 16, 14, 13, 11
function automatic logic step_lfsr();
    logic fb;
    fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
    lfsr = {lfsr[14:0], fb};
    return fb;
endfunction

function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
        v = {v[6:0], step_lfsr()};
    return v;
endfunction

function automatic logic [DW-1:0] clamp_comp(input int v);
    if (v < 0)
        return '0;
    if (v > (1 << DW) - 1)
        return '1;
    return v[DW-1:0];
endfunction

function automatic pixel_t ref_csc(input pixel_t rgb);
    int     r;
    int     g;
    int     b;
    pixel_t ycc;
    r      = rgb.c0;
    g      = rgb.c1;
    b      = rgb.c2;
    ycc.c0 = clamp_comp((77*r + 150*g + 29*b + 128) >>> 8);
    ycc.c1 = clamp_comp(((-43*r - 85*g + 128*b + 128) >>> 8) + 128);
    ycc.c2 = clamp_comp(((128*r - 107*g - 21*b + 128) >>> 8) + 128);
    return ycc;
endfunction

// Expected sample streams of one frame, in output order
task automatic build_expected(input bit csc, input bit m420);
    pixel_t        conv [YS][XS];
    logic [DW-1:0] avg;
    for (int ln = 0; ln < YS; ln++) begin
        for (int px = 0; px < XS; px++) begin
            conv[ln][px] = csc ? ref_csc(frame_pix[ln][px]) : frame_pix[ln][px];
            y_q.push_back(conv[ln][px].c0);
            if (!m420) begin
                cb_q.push_back(conv[ln][px].c1);
                cr_q.push_back(conv[ln][px].c2);
            end else if (ln % 2 == 1 && px % 2 == 1) begin
                avg = (conv[ln-1][px-1].c1 + conv[ln-1][px].c1 + conv[ln][px-1].c1
                       + conv[ln][px].c1 + 2) >> 2;  // Rounded 2x2 mean
                cb_q.push_back(avg);
                avg = (conv[ln-1][px-1].c2 + conv[ln-1][px].c2 + conv[ln][px-1].c2
                       + conv[ln][px].c2 + 2) >> 2;
                cr_q.push_back(avg);
            end
        end
    end
    frame_420_q.push_back(m420);
endtask

// One advancing cycle, preceded by random hold cycles when stressed
task automatic drive_cycle(input pixel_t pix, input logic pv, input raster_t rs);
    @(posedge clk);
    #2;
    pixel_i       = pix;
    pixel_valid_i = pv;
    raster_i      = rs;
    hold_i        = stress_on && (rand_bits(2) == 0);  // About one cycle in four
    while (hold_i) begin
        @(posedge clk);
        #2;
        hold_i = (rand_bits(2) == 0);
    end
endtask

task automatic cfg_write(input cfg_addr_t addr, input logic data);
    @(posedge clk);
    #2;
    cfg_we_i    = 1'b1;
    cfg_addr_i  = addr;
    cfg_wdata_i = data;
    @(posedge clk);
    #2;
    cfg_we_i = 1'b0;
    if (addr == CFG_CSC_EN)
        pend_csc = data;
    else
        pend_420 = data;
endtask

task automatic run_frame(input bit stress, input bit wr_csc, input bit new_csc,
                         input bit wr_mode, input bit new_420);
    stress_on = stress;
    for (int ln = 0; ln < YS; ln++)
        for (int px = 0; px < XS; px++)
            frame_pix[ln][px] = {rand_bits(8), rand_bits(8), rand_bits(8)};
    build_expected(pend_csc, pend_420);  // Pending settings go active at frame start
    repeat (2) drive_cycle('0, 1'b0, 2'b10);
    for (int ln = 0; ln < YS; ln++) begin
        for (int px = 0; px < XS; px++) begin
            if (stress && rand_bits(2) == 0)
                drive_cycle(frame_pix[ln][px], 1'b0, 2'b11);  // Gap in pixel valid
            drive_cycle(frame_pix[ln][px], 1'b1, 2'b11);
        end
        repeat (3) drive_cycle('0, 1'b0, 2'b10);
        if (ln == YS/2 - 1) begin
            if (wr_csc)
                cfg_write(CFG_CSC_EN, new_csc);
            if (wr_mode)
                cfg_write(CFG_MODE, new_420);
        end
    end
    repeat (10) drive_cycle('0, 1'b0, 2'b00);  // Frame gap and pipeline flush
endtask

task automatic pop_and_compare(input int comp, input logic [DW-1:0] got);
    logic [DW-1:0] exp;
    bit            found;
    found = 1'b0;
    if (comp == 0 && y_q.size() > 0) begin
        exp   = y_q.pop_front();
        found = 1'b1;
    end else if (comp == 1 && cb_q.size() > 0) begin
        exp   = cb_q.pop_front();
        found = 1'b1;
    end else if (comp == 2 && cr_q.size() > 0) begin
        exp   = cr_q.pop_front();
        found = 1'b1;
    end
    if (!found) begin
        $display("Component %0d produced a sample with none expected at %0t", comp, $time);
        err_other++;
    end else if (got !== exp) begin
        $display("Error %0t: component %0d expected %h got %h", $time, comp, exp, got);
        err_value++;
    end
endtask

// Outputs are new only after an edge with hold low
always @(negedge clk) begin
    if (hold_o !== hold_i) begin
        $display("Error %0t: hold_o %b differs from hold_i %b", $time, hold_o, hold_i);
        err_value++;
    end
    if (resetn && fresh) begin
        if (comp_valid_o[0]) begin
            luma_seen++;
            pop_and_compare(0, pixel_o.c0);
            if (pixel_count_o != exp_px || line_count_o != exp_ln) begin
                $display("Error %0t: luma at pixel %0d line %0d, expected pixel %0d line %0d",
                         $time, pixel_count_o, line_count_o, exp_px, exp_ln);
                err_value++;
            end
            if (raster_o !== 2'b11) begin
                $display("Error %0t: luma valid with raster %b, expected 11", $time, raster_o);
                err_value++;
            end
            exp_px = (exp_px + 1) % XS;
            if (exp_px == 0)
                exp_ln = (exp_ln + 1) % YS;
        end
        if (comp_valid_o[1]) begin
            chroma_seen++;
            pop_and_compare(1, pixel_o.c1);
        end
        if (comp_valid_o[2])
            pop_and_compare(2, pixel_o.c2);
        if (|comp_valid_o[2:1] && frame_420_q.size() > 0 && frame_420_q[0]
            && !line_count_o[0]) begin
            $display("Error %0t: chroma valid on even line %0d in 4:2:0", $time, line_count_o);
            err_value++;
        end
        if (eol_o) begin
            eol_in_frame++;
            if (raster_o.line_valid !== 1'b0) begin
                $display("Error %0t: eol_o with line_valid still high on raster_o", $time);
                err_value++;
            end
        end
        if (eof_o) begin
            eof_count++;
            if (raster_o.frame_valid !== 1'b0) begin
                $display("Error %0t: eof_o with frame_valid still high on raster_o", $time);
                err_value++;
            end
            if (eol_in_frame != YS) begin
                $display("Frame %0d ended after %0d line ends instead of %0d",
                         eof_count, eol_in_frame, YS);
                err_other++;
            end
            eol_in_frame = 0;
            if (frame_420_q.size() > 0)
                frame_420_q.delete(0);
        end
    end
    fresh = !hold_i;  // Governs the coming rising edge
end

initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles before all frames finished", WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
end

initial begin
    resetn        = 1'b0;
    pixel_i       = '0;
    pixel_valid_i = 1'b0;
    raster_i      = '0;
    hold_i        = 1'b0;
    cfg_we_i      = 1'b0;
    cfg_addr_i    = CFG_CSC_EN;
    cfg_wdata_i   = 1'b0;
    lfsr          = 16'd8860;
    pend_csc      = 1'b1;  // Reset defaults of the config block
    pend_420      = 1'b1;
    repeat (5) @(posedge clk);
    #2;
    resetn = 1'b1;
    @(negedge clk);
    if (comp_valid_o !== 3'b000 || raster_o !== 2'b00 || eof_o !== 1'b0 || eol_o !== 1'b0) begin
        $display("Error %0t: outputs not idle after reset, valid %b raster %b eof %b eol %b",
                 $time, comp_valid_o, raster_o, eof_o, eol_o);
        err_value++;
    end
    run_frame(1'b0, 1'b0, 1'b0, 1'b1, 1'b0);
    run_frame(1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
    run_frame(1'b0, 1'b1, 1'b1, 1'b0, 1'b0);
    run_frame(1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    run_frame(1'b1, 1'b0, 1'b0, 1'b1, 1'b0);
    run_frame(1'b1, 1'b1, 1'b0, 1'b1, 1'b1);
    run_frame(1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    repeat (4) @(posedge clk);
    @(negedge clk);
    if (y_q.size() != 0 || cb_q.size() != 0 || cr_q.size() != 0) begin
        $display("Samples never appeared: %0d Y, %0d Cb, %0d Cr",
                 y_q.size(), cb_q.size(), cr_q.size());
        err_other++;
    end
    if (eof_count != NUM_FRAMES) begin
        $display("Saw %0d frame ends for %0d frames", eof_count, NUM_FRAMES);
        err_other++;
    end
    $display("Checked %0d luma and %0d chroma samples: %0d value errors, %0d other errors",
             luma_seen, chroma_seen, err_value, err_other);
    if (err_value + err_other == 0) begin
        $display("Simulation PASSED");
    end else begin
        $display("Simulation FAILED");
    end
    $finish;
end

endmodule
